// File: Makefile
# Verilator build and run for pad_tb

VERILATOR ?= verilator
TOP       ?= pad_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when the file list or a source changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/nes_pad_model.sv
`timescale 1ns/100ps

module nes_pad_model (
    input  logic       nes_latch,   // from the poller
    input  logic       nes_clk,
    input  logic [7:0] pattern,     // pressed = 1, bit 0 = a ... bit 7 = right
    output logic       nes_data     // active low like a real pad
);

    logic [7:0] shift_q = 8'h00;   // nothing pressed until the first latch

    // parallel load on latch, a is on the line straight away
    // shift on clk rise like the 4021 inside the pad
    always @(posedge nes_clk or posedge nes_latch) begin
        if (nes_latch) begin
            shift_q <= pattern;
        end else begin
            shift_q <= {1'b0, shift_q[7:1]};  // released fills in behind
        end
    end

    assign nes_data = ~shift_q[0];  // low = pressed

endmodule

// File: bench/pad_tb.sv
`timescale 1ns/100ps

module pad_tb;

    import pad_pkg::*;

    localparam logic [10:0] LATCH_CYCLES = 11'd24;
    localparam logic [10:0] HALF_CYCLES  = 11'd12;
    localparam int          SNES_HOLD    = 3;     // clk cycles per pmod half period
    localparam int          WAIT_LIMIT   = 2000;  // well over one nes frame

    logic       clk;
    logic       rst_n;
    logic       nes_data;
    logic       snes_data;
    logic       snes_clk;
    logic       snes_latch;
    logic       nes_latch;
    logic       nes_clk;
    buttons_t   buttons;
    logic       snes_active;

    logic [7:0]  nes_pattern;   // pressed = 1 in read order
    logic [31:0] lcg_state;
    logic        snes_sent;     // first pmod latch has gone out
    int          value_errs;
    int          timing_errs;

    // nes waveform measurement
    int   latch_len;
    int   clk_len;
    int   clk_pulses;
    logic latch_prev;
    logic clk_prev;
    logic seen_latch;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    pad_top #(
        .LATCH_CYCLES (LATCH_CYCLES),
        .HALF_CYCLES  (HALF_CYCLES)
    ) u_pad_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .nes_data    (nes_data),
        .snes_data   (snes_data),
        .snes_clk    (snes_clk),
        .snes_latch  (snes_latch),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .buttons     (buttons),
        .snes_active (snes_active)
    );

    nes_pad_model u_nes_pad_model (
        .nes_latch (nes_latch),
        .nes_clk   (nes_clk),
        .pattern   (nes_pattern),
        .nes_data  (nes_data)
    );

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];  // upper bits since low ones cycle fast
    endfunction

    function automatic int count_ones(input logic [SNES_FRAME_BITS-1:0] f);
        int n;
        n = 0;
        for (int i = 0; i < SNES_FRAME_BITS; i++) begin
            n += int'(f[i]);
        end
        return n;
    endfunction

    // nes read order a b select start up down left right
    function automatic buttons_t nes_expect(input logic [7:0] p);
        buttons_t e;
        e        = '0;   // x y l r absent on nes
        e.a      = p[0];
        e.b      = p[1];
        e.select = p[2];
        e.start  = p[3];
        e.up     = p[4];
        e.down   = p[5];
        e.left   = p[6];
        e.right  = p[7];
        return e;
    endfunction

    task automatic give_up(input string what);
        $display("Timeout: %s", what);
        $display("errors: %0d value, %0d timing", value_errs, timing_errs);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // returns on the first negedge where nes_latch is seen newly high
    task automatic wait_nes_latch_rise();
        int   n;
        logic was_high;
        n        = 0;
        was_high = 1'b1;  // a pulse already running does not count
        while (!(nes_latch && !was_high)) begin
            if (n == WAIT_LIMIT) begin
                give_up("nes_latch never rose");
            end
            was_high = nes_latch;
            @(negedge clk);
            n++;
        end
    endtask

    task automatic expect_buttons(input buttons_t exp);
        assert (buttons == exp) else begin
            $display("Fail buttons: got %h expected %h", 12'(buttons), 12'(exp));
            value_errs++;
        end
    endtask

    task automatic expect_active(input logic exp);
        assert (snes_active == exp) else begin
            $display("Fail snes_active: got %h expected %h", snes_active, exp);
            value_errs++;
        end
    endtask

    // msb first with 1 as pressed
    // latch stays high on return
    task automatic send_snes_frame(input logic [SNES_FRAME_BITS-1:0] bits);
        snes_latch = 1'b0;
        for (int n = SNES_FRAME_BITS - 1; n >= 0; n--) begin
            snes_data = bits[n];  // first out lands in b
            snes_clk  = 1'b0;
            repeat (SNES_HOLD) @(negedge clk);
            snes_clk = 1'b1;
            repeat (SNES_HOLD) @(negedge clk);
        end
        snes_clk = 1'b0;
        repeat (SNES_HOLD) @(negedge clk);
        snes_latch = 1'b1;
        snes_sent  = 1'b1;
        repeat (5) @(negedge clk);  // capture lands 3 clocks after the edge
    endtask

    // outputs while held in reset
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!nes_latch && !nes_clk) else begin
                $display("Fail nes_latch/nes_clk in reset: got %h %h", nes_latch, nes_clk);
                value_errs++;
            end
            expect_buttons('0);
            expect_active(1'b0);
        end
    end

    // latch length, clk pulse length, clk pulses per frame
    always @(negedge clk) begin
        if (!rst_n) begin
            latch_len  = 0;
            clk_len    = 0;
            clk_pulses = 0;
            latch_prev = 1'b0;
            clk_prev   = 1'b0;
            seen_latch = 1'b0;
        end else begin
            if (nes_latch) latch_len++;
            if (nes_clk) clk_len++;
            if (!nes_latch && latch_prev) begin
                assert (latch_len == int'(LATCH_CYCLES) + 1) else begin
                    $display("Fail nes_latch width: got %h expected %h",
                             latch_len, int'(LATCH_CYCLES) + 1);
                    timing_errs++;
                end
                latch_len = 0;
            end
            if (nes_latch && !latch_prev) begin
                if (seen_latch) begin
                    assert (clk_pulses == 7) else begin
                        $display("Fail nes_clk pulse count: got %h expected %h",
                                 clk_pulses, 7);
                        timing_errs++;
                    end
                end
                seen_latch = 1'b1;
                clk_pulses = 0;
            end
            if (!nes_clk && clk_prev) begin
                assert (clk_len == int'(HALF_CYCLES) + 1) else begin
                    $display("Fail nes_clk width: got %h expected %h",
                             clk_len, int'(HALF_CYCLES) + 1);
                    timing_errs++;
                end
                clk_len = 0;
                clk_pulses++;
            end
            latch_prev = nes_latch;
            clk_prev   = nes_clk;
        end
    end

    no_clk_in_latch: assert property (@(posedge clk) disable iff (!rst_n)
                                      !(nes_clk && nes_latch))
        else begin
            $display("nes_clk was high while nes_latch was high");
            timing_errs++;
        end

    idle_until_snes: assert property (@(posedge clk) disable iff (!rst_n)
                                      !snes_sent |-> !snes_active)
        else begin
            $display("Fail snes_active before first frame: got %h expected %h",
                     $sampled(snes_active), 1'b0);
            value_errs++;
        end

    initial begin
        logic [15:0]                rnd;
        logic [SNES_FRAME_BITS-1:0] f;
        int                         i;
        int                         j;
        int                         tries;
        rst_n       = 1'b0;
        snes_data   = 1'b0;  // pmod lines idle low
        snes_clk    = 1'b0;
        snes_latch  = 1'b0;
        snes_sent   = 1'b0;
        nes_pattern = 8'h00;
        value_errs  = 0;
        timing_errs = 0;
        lcg_state   = 32'd29;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // nes only where two latch rises cover one whole frame of the new pattern
        for (int k = 0; k < 4; k++) begin
            rnd         = rand16();
            nes_pattern = rnd[7:0];
            wait_nes_latch_rise();
            wait_nes_latch_rise();
            expect_buttons(nes_expect(nes_pattern));
            expect_active(1'b0);
        end

        // snes with up to two pressed and the first frame empty
        for (int k = 0; k < 6; k++) begin
            rnd = rand16();
            i   = int'(rnd % 16'd12);
            rnd = rand16();
            j   = int'(rnd % 16'd12);
            f   = (k == 0) ? '0 : ((12'b1 << i) | (12'b1 << j));
            send_snes_frame(f);
            expect_active(1'b1);
            expect_buttons(buttons_t'(f));
        end

        // three or more pressed reads as a glitch
        for (int k = 0; k < 3; k++) begin
            f     = '1;
            tries = 0;
            while ((count_ones(f) <= int'(MAX_PRESSED) || f == '1) && tries < 100) begin
                rnd = rand16();
                f   = rnd[SNES_FRAME_BITS-1:0];
                tries++;
            end
            if (tries == 100) f = 12'h007 << k;  // fallback of three adjacent bits
            send_snes_frame(f);
            expect_active(1'b1);
            expect_buttons('0);
        end

        // pad unplugged so nes takes over again
        send_snes_frame('1);
        expect_active(1'b0);
        wait_nes_latch_rise();
        wait_nes_latch_rise();
        expect_buttons(nes_expect(nes_pattern));
        rnd         = rand16();
        nes_pattern = rnd[15:8];
        wait_nes_latch_rise();
        wait_nes_latch_rise();
        expect_buttons(nes_expect(nes_pattern));

        $display("errors: %0d value, %0d timing", value_errs, timing_errs);
        if (value_errs == 0 && timing_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: logic/nes_poller.sv
`timescale 1ns/100ps

module nes_poller #(
    parameter logic [10:0] LATCH_CYCLES = 11'd768,  // 12 us at 64 MHz
    parameter logic [10:0] HALF_CYCLES  = 11'd384   // 6 us at 64 MHz
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             nes_data,     // serial line from pad, active low
    output logic             nes_latch,
    output logic             nes_clk,
    output pad_pkg::buttons_t nes_buttons
);

    import pad_pkg::*;

    nes_state_t  state_q;
    nes_state_t  state_nxt;
    logic [10:0] count_q;     // cycles into current slot
    logic [7:0]  raw_q;       // samples as read off the line, bit n from slot n+1
    logic [2:0]  bit_idx;     // which raw bit the current slot owns
    logic        slot_last;   // final cycle of the slot
    logic        sample;      // capture nes_data this cycle
    logic        bit_slot;    // one of the seven clocked slots

    // read_a owns bit 0 ... read_right owns bit 7
    assign bit_idx = 3'(state_q - 4'd1);

    // slot rules shared by every clocked slot
    always_comb begin
        slot_last = 1'b0;
        sample    = 1'b0;
        bit_slot  = 1'b0;
        case (state_q)
            latch: begin
                slot_last = (count_q == LATCH_CYCLES);
            end
            read_a: begin
                slot_last = (count_q == HALF_CYCLES);  // short slot, clk stays low
                sample    = (count_q == 11'd0);        // a is valid once latch drops
            end
            read_b, read_select, read_start, read_up,
            read_down, read_left, read_right: begin
                bit_slot  = 1'b1;
                slot_last = (count_q == LATCH_CYCLES);
                sample    = (count_q == HALF_CYCLES);  // mid pulse
            end
            default: begin
                slot_last = 1'b1;  // illegal code, resync at latch
            end
        endcase
    end

    // walk the slots in read order, wrap after right
    always_comb begin
        if (state_q == read_right || !bit_slot && state_q != latch && state_q != read_a) begin
            state_nxt = latch;
        end else begin
            state_nxt = nes_state_t'(state_q + 4'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= latch;   // first pulse right after reset
            count_q   <= '0;
            raw_q     <= '1;      // line idles high = released
            nes_latch <= 1'b0;
            nes_clk   <= 1'b0;
        end else begin
            // pin waveforms trail the slot by one cycle
            nes_latch <= (state_q == latch);
            nes_clk   <= bit_slot && (count_q <= HALF_CYCLES);

            if (sample) begin
                raw_q[bit_idx] <= nes_data;
            end

            if (slot_last) begin
                count_q <= '0;
                state_q <= state_nxt;
            end else begin
                count_q <= count_q + 11'd1;
            end
        end
    end

    // pad is active low, flip to pressed = 1
    always_comb begin
        nes_buttons        = '0;  // x y l r do not exist on nes
        nes_buttons.a      = ~raw_q[0];
        nes_buttons.b      = ~raw_q[1];
        nes_buttons.select = ~raw_q[2];
        nes_buttons.start  = ~raw_q[3];
        nes_buttons.up     = ~raw_q[4];
        nes_buttons.down   = ~raw_q[5];
        nes_buttons.left   = ~raw_q[6];
        nes_buttons.right  = ~raw_q[7];
    end

endmodule

// File: logic/pad_pkg.sv
package pad_pkg;

    // button word, 1 = pressed
    // field order follows the snes shift order, first bit in lands in b
    typedef struct packed {
        logic b;
        logic y;
        logic select;
        logic start;
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic x;
        logic l;
        logic r;
    } buttons_t;

    // bits per snes frame
    localparam int unsigned SNES_FRAME_BITS = 12;

    // more pressed buttons than this reads as a glitch
    localparam int unsigned MAX_PRESSED = 2;

    // nes poller slots in read order
    typedef enum logic [3:0] {
        latch       = 4'd0,  // latch pulse
        read_a      = 4'd1,  // a sits on the line right after latch
        read_b      = 4'd2,
        read_select = 4'd3,
        read_start  = 4'd4,
        read_up     = 4'd5,
        read_down   = 4'd6,
        read_left   = 4'd7,
        read_right  = 4'd8   // last slot, back to latch after
    } nes_state_t;

endpackage

// File: logic/pad_top.sv
`timescale 1ns/100ps

module pad_top #(
    parameter logic [10:0] LATCH_CYCLES = 11'd768,  // latch and bit slot length - 1
    parameter logic [10:0] HALF_CYCLES  = 11'd384   // clk high time - 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              nes_data,     // nes pad serial out
    input  logic              snes_data,    // snes pmod lines
    input  logic              snes_clk,
    input  logic              snes_latch,
    output logic              nes_latch,    // to nes pad
    output logic              nes_clk,
    output pad_pkg::buttons_t buttons,      // merged button state
    output logic              snes_active   // 1 = snes source, 0 = nes
);

    import pad_pkg::*;

    buttons_t                   nes_buttons;
    buttons_t                   snes_buttons;
    logic [SNES_FRAME_BITS-1:0] frame;
    logic                       present;

    // active polling of the nes pad
    nes_poller #(
        .LATCH_CYCLES (LATCH_CYCLES),
        .HALF_CYCLES  (HALF_CYCLES)
    ) u_nes_poller (
        .clk         (clk),
        .rst_n       (rst_n),
        .nes_data    (nes_data),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .nes_buttons (nes_buttons)
    );

    // passive listener on the pmod stream
    snes_pmod_receiver u_snes_pmod_receiver (
        .clk        (clk),
        .rst_n      (rst_n),
        .snes_data  (snes_data),
        .snes_clk   (snes_clk),
        .snes_latch (snes_latch),
        .frame      (frame)
    );

    snes_decoder u_snes_decoder (
        .frame        (frame),
        .snes_buttons (snes_buttons),
        .present      (present)
    );

    // snes wins whenever a pad answers
    assign buttons     = present ? snes_buttons : nes_buttons;
    assign snes_active = present;

endmodule

// File: logic/snes_decoder.sv
`timescale 1ns/100ps

module snes_decoder (
    input  logic [pad_pkg::SNES_FRAME_BITS-1:0] frame,
    output pad_pkg::buttons_t                   snes_buttons,
    output logic                                present
);

    import pad_pkg::*;

    localparam int unsigned CNT_W = $clog2(SNES_FRAME_BITS + 1);

    logic [CNT_W-1:0] pressed_cnt;  // set bits in the frame
    logic             too_many;

    // floating data line reads all ones
    assign present = ~&frame;

    // popcount over the whole frame
    always_comb begin
        pressed_cnt = '0;
        for (int i = 0; i < SNES_FRAME_BITS; i++) begin
            pressed_cnt = pressed_cnt + CNT_W'(frame[i]);
        end
    end

    // adapter sometimes hands over junk frames with lots of bits set
    assign too_many = (pressed_cnt > MAX_PRESSED);

    // struct order is shift order, map straight across
    always_comb begin
        if (!present || too_many) begin
            snes_buttons = '0;  // absent or glitch, all released
        end else begin
            snes_buttons = buttons_t'(frame);
        end
    end

endmodule

// File: logic/snes_pmod_receiver.sv
`timescale 1ns/100ps

module snes_pmod_receiver (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                snes_data,   // pmod data line
    input  logic                                snes_clk,    // pmod shift clock
    input  logic                                snes_latch,  // pmod frame strobe
    output logic [pad_pkg::SNES_FRAME_BITS-1:0] frame
);

    import pad_pkg::*;

    logic [1:0] data_sync;
    logic [1:0] clk_sync;
    logic [1:0] latch_sync;
    logic       clk_prev;    // edge register
    logic       latch_prev;
    logic       clk_rise;
    logic       latch_rise;
    logic [SNES_FRAME_BITS-1:0] shift_q;

    // rising edges seen after the second sync stage
    assign clk_rise   = clk_sync[1] & ~clk_prev;
    assign latch_rise = latch_sync[1] & ~latch_prev;

    // two flops per line, adapter runs on its own clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_sync  <= '0;
            clk_sync   <= '0;
            latch_sync <= '0;
            clk_prev   <= 1'b0;
            latch_prev <= 1'b0;
        end else begin
            data_sync  <= {data_sync[0], snes_data};
            clk_sync   <= {clk_sync[0], snes_clk};
            latch_sync <= {latch_sync[0], snes_latch};
            clk_prev   <= clk_sync[1];
            latch_prev <= latch_sync[1];
        end
    end

    // all ones after reset so the decoder reports no pad
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q <= '1;
            frame   <= '1;
        end else begin
            if (clk_rise) begin
                shift_q <= {shift_q[SNES_FRAME_BITS-2:0], data_sync[1]};  // in at lsb
            end
            if (latch_rise) begin
                frame <= shift_q;  // 3 clocks after the pin edge
            end
        end
    end

endmodule

// File: sources.f
logic/pad_pkg.sv
logic/nes_poller.sv
logic/snes_pmod_receiver.sv
logic/snes_decoder.sv
logic/pad_top.sv
bench/nes_pad_model.sv
bench/pad_tb.sv
